// File: hw/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry
`define CACHE_SETS 8

// address fields
`define IDX_W 3
`define TAG_W 26

// backing RAM
`define RAM_WORDS 1024
`define RAM_LATENCY 2

`endif

// File: hw/cpu_types_pkg.sv
`include "cache_params.svh"

package cpu_types_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // address bits 31 to 6
    typedef logic [`TAG_W-1:0] tag_t;

    // address bits 5 to 3
    typedef logic [`IDX_W-1:0] idx_t;

endpackage

// File: hw/coherence_pkg.sv
package coherence_pkg;

    // cache controller states
    typedef enum logic [3:0] {
        IDLE, UPGRADE, WRITEBACK_ONE, WRITEBACK_TWO, FETCH_ONE, FETCH_TWO,
        OVERWRITE, FLUSH, FLUSHED
    } dcache_state_e;

    // bus sequencer states
    typedef enum logic [2:0] {
        ARB, SNOOP, SNOOP_ONE, SNOOP_TWO, RAM_ONE, RAM_TWO, INVAL
    } bus_state_e;

endpackage

// File: hw/dcache.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module dcache import cpu_types_pkg::*, coherence_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  dmemren,
    input  logic  dmemwen,
    input  logic  halt,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    output word_t dmemload,
    output logic  dhit,
    output logic  flushed,
    output logic  bus_ren,
    output logic  bus_wen,
    output logic  cc_trans,
    output logic  cc_write,
    output word_t bus_addr,
    output word_t bus_store,
    input  logic  bus_wait,
    input  word_t bus_load,
    input  logic  cc_wait,
    input  logic  cc_inv,
    input  word_t cc_snoopaddr,
    output logic  cc_hit,
    output logic  cc_dirty,
    output word_t cc_snoopdata
);

    // two ways, one block of two words per set
    word_t data_one [2][`CACHE_SETS];
    word_t data_two [2][`CACHE_SETS];
    tag_t  tags     [2][`CACHE_SETS];
    logic  valid    [2][`CACHE_SETS];
    logic  dirty    [2][`CACHE_SETS];
    logic  recent   [2][`CACHE_SETS];

    dcache_state_e state, next_state;
    logic [4:0]    slot;
    word_t         fill_word;

    tag_t       tag;
    idx_t       idx;
    logic       blk;
    logic [1:0] match;
    logic       hit;
    logic       hway;
    logic       vway;
    logic       vdirty;

    tag_t       s_tag;
    idx_t       s_idx;
    logic [1:0] s_match;
    logic       s_way;

    logic f_way;
    idx_t f_idx;
    logic f_word;
    logic f_dirty;

    // cpu request decode
    assign tag      = dmemaddr[31:6];
    assign idx      = dmemaddr[5:3];
    assign blk      = dmemaddr[2];
    assign match[0] = valid[0][idx] && (tags[0][idx] == tag);
    assign match[1] = valid[1][idx] && (tags[1][idx] == tag);
    assign hit      = |match;
    assign hway     = match[1];
    assign dmemload = blk ? data_two[hway][idx] : data_one[hway][idx];

    // victim is the way without the recent bit
    assign vway   = recent[0][idx];
    assign vdirty = valid[vway][idx] && dirty[vway][idx];

    // snoop lookup, same arrays
    assign s_tag        = cc_snoopaddr[31:6];
    assign s_idx        = cc_snoopaddr[5:3];
    assign s_match[0]   = valid[0][s_idx] && (tags[0][s_idx] == s_tag);
    assign s_match[1]   = valid[1][s_idx] && (tags[1][s_idx] == s_tag);
    assign s_way        = s_match[1];
    assign cc_hit       = |s_match;
    assign cc_dirty     = cc_hit && dirty[s_way][s_idx];
    assign cc_snoopdata = cc_snoopaddr[2] ? data_two[s_way][s_idx] : data_one[s_way][s_idx];

    // flush slot is {way, set, word}
    assign f_way   = slot[4];
    assign f_idx   = slot[3:1];
    assign f_word  = slot[0];
    assign f_dirty = valid[f_way][f_idx] && dirty[f_way][f_idx];

    always_comb begin
        next_state = state;
        dhit       = 1'b0;
        flushed    = 1'b0;
        bus_ren    = 1'b0;
        bus_wen    = 1'b0;
        cc_trans   = 1'b0;
        cc_write   = 1'b0;
        bus_addr   = dmemaddr;
        bus_store  = '0;
        case (state)
            IDLE: begin
                if (halt) begin
                    next_state = FLUSH;
                end else if (!cc_wait && (dmemren || dmemwen)) begin
                    if (hit) begin
                        if (dmemren)
                            dhit = 1'b1;
                        else if (dirty[hway][idx])
                            next_state = OVERWRITE;
                        else
                            next_state = UPGRADE;
                    end else if (vdirty) begin
                        next_state = WRITEBACK_ONE;
                    end else begin
                        next_state = FETCH_ONE;
                    end
                end
            end
            UPGRADE: begin
                cc_trans = 1'b1;
                cc_write = 1'b1;
                if (!bus_wait)
                    next_state = OVERWRITE;
            end
            WRITEBACK_ONE, WRITEBACK_TWO: begin
                bus_wen  = 1'b1;
                bus_addr = {tags[vway][idx], idx, state == WRITEBACK_TWO, 2'b00};
                bus_store = (state == WRITEBACK_TWO) ? data_two[vway][idx] : data_one[vway][idx];
                if (!bus_wait)
                    next_state = (state == WRITEBACK_TWO) ? FETCH_ONE : WRITEBACK_TWO;
            end
            FETCH_ONE, FETCH_TWO: begin
                bus_ren  = 1'b1;
                cc_trans = 1'b1;
                cc_write = dmemwen;
                bus_addr = {tag, idx, state == FETCH_TWO, 2'b00};
                if (!bus_wait) begin
                    if (state == FETCH_ONE)
                        next_state = FETCH_TWO;
                    else
                        next_state = dmemwen ? OVERWRITE : IDLE;
                end
            end
            OVERWRITE: begin
                // line may have been lost to a snoop, IDLE then retries
                if (!cc_wait) begin
                    next_state = IDLE;
                    dhit       = hit;
                end
            end
            FLUSH: begin
                bus_wen   = f_dirty;
                bus_addr  = {tags[f_way][f_idx], f_idx, f_word, 2'b00};
                bus_store = f_word ? data_two[f_way][f_idx] : data_one[f_way][f_idx];
                if ((!f_dirty || !bus_wait) && slot == 5'd31)
                    next_state = FLUSHED;
            end
            FLUSHED: begin
                flushed = 1'b1;
                if (!halt)
                    next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // line state
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            slot  <= '0;
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `CACHE_SETS; s++) begin
                    valid[w][s]  <= 1'b0;
                    dirty[w][s]  <= 1'b0;
                    recent[w][s] <= 1'b0;
                end
            end
        end else begin
            state <= next_state;
            // snooped line drops to shared, or to invalid on cc_inv
            if (cc_wait && cc_hit) begin
                dirty[s_way][s_idx] <= 1'b0;
                if (cc_inv)
                    valid[s_way][s_idx] <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (dhit) begin
                        recent[hway][idx]  <= 1'b1;
                        recent[~hway][idx] <= 1'b0;
                    end
                end
                OVERWRITE: begin
                    if (dhit) begin
                        dirty[hway][idx]   <= 1'b1;
                        recent[hway][idx]  <= 1'b1;
                        recent[~hway][idx] <= 1'b0;
                    end
                end
                FETCH_TWO: begin
                    if (!bus_wait) begin
                        valid[vway][idx]   <= 1'b1;
                        dirty[vway][idx]   <= 1'b0;
                        recent[vway][idx]  <= 1'b1;
                        recent[~vway][idx] <= 1'b0;
                    end
                end
                FLUSH: begin
                    if (!f_dirty || !bus_wait)
                        slot <= slot + 5'd1;
                end
                default: ;
            endcase
            if (state == FLUSH && next_state == FLUSHED) begin
                for (int w = 0; w < 2; w++) begin
                    for (int s = 0; s < `CACHE_SETS; s++) begin
                        valid[w][s]  <= 1'b0;
                        dirty[w][s]  <= 1'b0;
                        recent[w][s] <= 1'b0;
                    end
                end
            end
        end
    end

    // payload
    always_ff @(posedge CLK) begin
        if (state == FETCH_ONE && !bus_wait)
            fill_word <= bus_load;
        if (state == FETCH_TWO && !bus_wait) begin
            data_one[vway][idx] <= fill_word;
            data_two[vway][idx] <= bus_load;
            tags[vway][idx]     <= tag;
        end
        if (state == OVERWRITE && dhit) begin
            if (blk)
                data_two[hway][idx] <= dmemstore;
            else
                data_one[hway][idx] <= dmemstore;
        end
    end

endmodule

// File: hw/bus_controller.sv
`timescale 1ns/1ps

module bus_controller import cpu_types_pkg::*, coherence_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  bus_ren      [2],
    input  logic  bus_wen      [2],
    input  logic  cc_trans     [2],
    input  logic  cc_write     [2],
    input  word_t bus_addr     [2],
    input  word_t bus_store    [2],
    output logic  bus_wait     [2],
    output word_t bus_load     [2],
    output logic  cc_wait      [2],
    output logic  cc_inv       [2],
    output word_t cc_snoopaddr [2],
    input  logic  cc_hit       [2],
    input  logic  cc_dirty     [2],
    input  word_t cc_snoopdata [2],
    output logic  ram_ren,
    output logic  ram_wen,
    output word_t ram_addr,
    output word_t ram_store,
    input  word_t ram_load,
    input  logic  ram_wait
);

    bus_state_e state, next_state;
    logic       grant;
    logic       prio;
    logic       coh;
    logic       upg;
    logic       wr;
    logic       snp_hit;
    logic [1:0] req;
    logic       pick;
    logic       other;
    logic       snoop_active;

    assign req[0] = bus_ren[0] || bus_wen[0] || cc_trans[0];
    assign req[1] = bus_ren[1] || bus_wen[1] || cc_trans[1];
    // round robin, prio names the favoured cache
    assign pick   = req[prio] ? prio : ~prio;
    assign other  = ~grant;
    assign snoop_active = (state inside {SNOOP, SNOOP_ONE, SNOOP_TWO, INVAL}) ||
                          (coh && (state inside {RAM_ONE, RAM_TWO}));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= ARB;
            grant   <= 1'b0;
            prio    <= 1'b0;
            coh     <= 1'b0;
            upg     <= 1'b0;
            wr      <= 1'b0;
            snp_hit <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ARB && |req) begin
                grant <= pick;
                prio  <= ~pick;
                coh   <= cc_trans[pick];
                upg   <= cc_trans[pick] && !bus_ren[pick] && !bus_wen[pick];
                wr    <= cc_write[pick];
            end
            if (state == SNOOP)
                snp_hit <= cc_hit[other];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ARB: begin
                if (|req)
                    next_state = cc_trans[pick] ? SNOOP : RAM_TWO;
            end
            SNOOP: begin
                if (upg)
                    next_state = INVAL;
                else if (cc_hit[other] && cc_dirty[other])
                    next_state = SNOOP_ONE;
                else
                    next_state = RAM_ONE;
            end
            SNOOP_ONE: if (!ram_wait) next_state = SNOOP_TWO;
            SNOOP_TWO: if (!ram_wait) next_state = (wr && snp_hit) ? INVAL : ARB;
            RAM_ONE:   if (!ram_wait) next_state = RAM_TWO;
            RAM_TWO:   if (!ram_wait) next_state = (coh && wr && snp_hit) ? INVAL : ARB;
            INVAL:     next_state = ARB;
            default:   next_state = ARB;
        endcase
    end

    always_comb begin
        bus_wait     = '{1'b1, 1'b1};
        bus_load     = '{32'd0, 32'd0};
        cc_wait      = '{1'b0, 1'b0};
        cc_inv       = '{1'b0, 1'b0};
        cc_snoopaddr = '{32'd0, 32'd0};
        ram_ren      = 1'b0;
        ram_wen      = 1'b0;
        ram_addr     = '0;
        ram_store    = '0;
        if (snoop_active) begin
            cc_wait[other]      = 1'b1;
            cc_snoopaddr[other] = bus_addr[grant];
        end
        case (state)
            SNOOP_ONE, SNOOP_TWO: begin
                // dirty copy goes to RAM and to the requester at once
                ram_wen         = 1'b1;
                ram_addr        = bus_addr[grant];
                ram_store       = cc_snoopdata[other];
                bus_load[grant] = cc_snoopdata[other];
                bus_wait[grant] = ram_wait;
            end
            RAM_ONE, RAM_TWO: begin
                ram_ren         = bus_ren[grant];
                ram_wen         = bus_wen[grant];
                ram_addr        = bus_addr[grant];
                ram_store       = bus_store[grant];
                bus_load[grant] = ram_load;
                bus_wait[grant] = ram_wait;
            end
            INVAL: begin
                cc_inv[other]   = wr && snp_hit;
                bus_wait[grant] = ~upg;
            end
            default: ;
        endcase
    end

endmodule

// File: hw/word_ram.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module word_ram import cpu_types_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  ren,
    input  logic  wen,
    input  word_t addr,
    input  word_t store,
    output word_t load,
    output logic  wait_out
);

    localparam int AW = $clog2(`RAM_WORDS);
    localparam int CW = $clog2(`RAM_LATENCY + 1);

    word_t         mem [`RAM_WORDS];
    logic [CW-1:0] cnt;
    logic [AW-1:0] waddr;
    logic          done;

    initial begin
        for (int i = 0; i < `RAM_WORDS; i++)
            mem[i] = '0;
    end

    assign waddr    = addr[AW+1:2];
    assign done     = (ren || wen) && (cnt == CW'(`RAM_LATENCY));
    assign wait_out = ~done;
    assign load     = mem[waddr];

    // latency count, back to zero after each completed access
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            cnt <= '0;
        else if (!(ren || wen) || done)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge CLK) begin
        if (wen && done)
            mem[waddr] <= store;
    end

endmodule

// File: hw/memory_system.sv
`timescale 1ns/1ps

module memory_system import cpu_types_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  dmemren   [2],
    input  logic  dmemwen   [2],
    input  logic  halt      [2],
    input  word_t dmemaddr  [2],
    input  word_t dmemstore [2],
    output word_t dmemload  [2],
    output logic  dhit      [2],
    output logic  flushed   [2]
);

    logic  bus_ren      [2];
    logic  bus_wen      [2];
    logic  cc_trans     [2];
    logic  cc_write     [2];
    word_t bus_addr     [2];
    word_t bus_store    [2];
    logic  bus_wait     [2];
    word_t bus_load     [2];
    logic  cc_wait      [2];
    logic  cc_inv       [2];
    word_t cc_snoopaddr [2];
    logic  cc_hit       [2];
    logic  cc_dirty     [2];
    word_t cc_snoopdata [2];

    logic  ram_ren;
    logic  ram_wen;
    word_t ram_addr;
    word_t ram_store;
    word_t ram_load;
    logic  ram_wait;

    for (genvar i = 0; i < 2; i++) begin : g_cpu
        dcache u_dcache (
            .CLK, .nRST,
            .dmemren(dmemren[i]), .dmemwen(dmemwen[i]), .halt(halt[i]),
            .dmemaddr(dmemaddr[i]), .dmemstore(dmemstore[i]), .dmemload(dmemload[i]),
            .dhit(dhit[i]), .flushed(flushed[i]),
            .bus_ren(bus_ren[i]), .bus_wen(bus_wen[i]),
            .cc_trans(cc_trans[i]), .cc_write(cc_write[i]),
            .bus_addr(bus_addr[i]), .bus_store(bus_store[i]),
            .bus_wait(bus_wait[i]), .bus_load(bus_load[i]),
            .cc_wait(cc_wait[i]), .cc_inv(cc_inv[i]), .cc_snoopaddr(cc_snoopaddr[i]),
            .cc_hit(cc_hit[i]), .cc_dirty(cc_dirty[i]), .cc_snoopdata(cc_snoopdata[i])
        );
    end

    bus_controller u_bus_controller (
        .CLK, .nRST,
        .bus_ren, .bus_wen, .cc_trans, .cc_write, .bus_addr, .bus_store,
        .bus_wait, .bus_load, .cc_wait, .cc_inv, .cc_snoopaddr,
        .cc_hit, .cc_dirty, .cc_snoopdata,
        .ram_ren, .ram_wen, .ram_addr, .ram_store, .ram_load, .ram_wait
    );

    word_ram u_word_ram (
        .CLK, .nRST,
        .ren(ram_ren), .wen(ram_wen), .addr(ram_addr), .store(ram_store),
        .load(ram_load), .wait_out(ram_wait)
    );

endmodule

// File: verification/memory_system_sva.sv
`timescale 1ns/1ps

module memory_system_sva (
    input logic CLK,
    input logic nRST,
    input logic cc_wait  [2],
    input logic cc_inv   [2],
    input logic bus_wait [2]
);

    // failed assertions, read by the testbench at the end of the run
    int violations = 0;

    // only the non-requesting cache is snooped
    one_snoop: assert property (@(posedge CLK) disable iff (!nRST)
        !(cc_wait[0] && cc_wait[1]))
    else begin
        violations++;
        $error("cc_wait high for both caches");
    end

    // invalidation only inside a snoop
    inv_in_snoop_0: assert property (@(posedge CLK) disable iff (!nRST)
        cc_inv[0] |-> cc_wait[0])
    else begin
        violations++;
        $error("cc_inv to cache 0 without cc_wait");
    end

    inv_in_snoop_1: assert property (@(posedge CLK) disable iff (!nRST)
        cc_inv[1] |-> cc_wait[1])
    else begin
        violations++;
        $error("cc_inv to cache 1 without cc_wait");
    end

    // one granted cache at a time
    one_grant: assert property (@(posedge CLK) disable iff (!nRST)
        bus_wait[0] || bus_wait[1])
    else begin
        violations++;
        $error("bus_wait low for both caches");
    end

endmodule

bind bus_controller memory_system_sva u_sva (
    .CLK(CLK),
    .nRST(nRST),
    .cc_wait(cc_wait),
    .cc_inv(cc_inv),
    .bus_wait(bus_wait)
);

// File: verification/memory_system_tb.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module memory_system_tb import cpu_types_pkg::*; ();

    localparam int addr_bits      = $clog2(`RAM_WORDS);
    localparam int timeout_cycles = 4000;

    logic  CLK;
    logic  nRST;
    logic  dmemren   [2];
    logic  dmemwen   [2];
    logic  halt      [2];
    word_t dmemaddr  [2];
    word_t dmemstore [2];
    word_t dmemload  [2];
    logic  dhit      [2];
    logic  flushed   [2];

    // last word written to each address by either cpu
    word_t shadow [`RAM_WORDS];
    word_t written [$];
    int    seed;

    memory_system UUT (
        .CLK, .nRST,
        .dmemren, .dmemwen, .halt, .dmemaddr, .dmemstore,
        .dmemload, .dhit, .flushed
    );

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    function automatic word_t expected_word(input word_t addr);
        return shadow[addr[addr_bits+1:2]];
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR t=%0t %s", $time, why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "first mismatch");
        end
    endtask

    // holds one request until dhit and counts the negedges waited
    task automatic cpu_access(input int cpu, input logic write, input word_t addr,
                              input word_t data, output int cycles);
        int waited;
        waited = 0;
        @(posedge CLK);
        dmemren[cpu]   <= !write;
        dmemwen[cpu]   <= write;
        dmemaddr[cpu]  <= addr;
        dmemstore[cpu] <= data;
        do begin
            @(negedge CLK);
            waited++;
            if (waited > timeout_cycles)
                abort_run($sformatf("cpu %0d got no dhit for address %h", cpu, addr));
        end while (!dhit[cpu]);
        cycles = waited;
        @(posedge CLK);
        dmemren[cpu] <= 1'b0;
        dmemwen[cpu] <= 1'b0;
    endtask

    task automatic write_word(input int cpu, input word_t addr, input word_t data);
        int cycles;
        cpu_access(cpu, 1'b1, addr, data, cycles);
        written.push_back(addr);
    endtask

    task automatic read_word(input int cpu, input word_t addr);
        int cycles;
        cpu_access(cpu, 1'b0, addr, '0, cycles);
    endtask

    // mixed traffic inside 256 bytes above base
    task automatic random_traffic(input int cpu, input word_t base, input int count);
        word_t addr;
        word_t data;
        word_t coin;
        for (int n = 0; n < count; n++) begin
            addr = base + (word_t'($random(seed)) & 32'h0000_00fc);
            data = $random(seed);
            coin = $random(seed);
            if (coin[0])
                write_word(cpu, addr, data);
            else
                read_word(cpu, addr);
        end
    endtask

    task automatic wait_flushed(input int cpu);
        int waited;
        waited = 0;
        while (!flushed[cpu]) begin
            @(negedge CLK);
            waited++;
            if (waited > timeout_cycles)
                abort_run($sformatf("cpu %0d never raised flushed", cpu));
        end
    endtask

    // reads are checked against the model and writes update it
    always @(negedge CLK) begin
        for (int i = 0; i < 2; i++) begin
            if (nRST && dhit[i]) begin
                if (dmemren[i])
                    check_value($sformatf("dmemload[%0d]", i), dmemload[i],
                                expected_word(dmemaddr[i]));
                else if (dmemwen[i])
                    shadow[dmemaddr[i][addr_bits+1:2]] = dmemstore[i];
            end
        end
    end

    initial begin
        int cycles;
        seed   = 32'hc729;
        nRST   = 1'b0;
        for (int i = 0; i < 2; i++) begin
            dmemren[i]   = 1'b0;
            dmemwen[i]   = 1'b0;
            halt[i]      = 1'b0;
            dmemaddr[i]  = '0;
            dmemstore[i] = '0;
        end
        foreach (shadow[k])
            shadow[k] = '0;
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;

        // read of an unwritten word then a write and a read that hits at once
        read_word(0, 32'h0000_0010);
        write_word(0, 32'h0000_0010, 32'hcafe_0001);
        cpu_access(0, 1'b0, 32'h0000_0010, '0, cycles);
        check_value("dhit latency", word_t'(cycles), 32'd1);

        // ownership moves between the caches
        write_word(0, 32'h0000_0120, 32'h1234_5678);
        read_word(1, 32'h0000_0120);
        write_word(1, 32'h0000_0120, 32'h8765_4321);
        read_word(0, 32'h0000_0120);

        // three tags on set 5
        write_word(0, 32'h0000_0028, 32'h0a0a_0001);
        write_word(0, 32'h0000_006c, 32'h0a0a_0002);
        write_word(0, 32'h0000_00a8, 32'h0a0a_0003);
        read_word(0, 32'h0000_0028);
        read_word(0, 32'h0000_006c);
        read_word(0, 32'h0000_00a8);

        fork
            random_traffic(0, 32'h0000_0400, 40);
            random_traffic(1, 32'h0000_0600, 40);
        join

        @(posedge CLK);
        halt[0] <= 1'b1;
        halt[1] <= 1'b1;
        fork
            wait_flushed(0);
            wait_flushed(1);
        join
        @(posedge CLK);
        halt[0] <= 1'b0;
        halt[1] <= 1'b0;

        // caches are empty now so every word comes back from RAM
        foreach (written[k])
            read_word(k % 2, written[k]);

        @(posedge CLK);
        if (UUT.u_bus_controller.u_sva.violations == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hw
hw/cpu_types_pkg.sv
hw/coherence_pkg.sv
hw/dcache.sv
hw/bus_controller.sv
hw/word_ram.sv
hw/memory_system.sv
verification/memory_system_sva.sv
verification/memory_system_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module memory_system_tb \
    -f filelist.f -Mdir obj_dir &&
./obj_dir/Vmemory_system_tb | tee /dev/stderr | grep -q "^Simulation finished: PASS$" &&
echo "run passed" ||
{ echo "run failed"; exit 1; }
